//--- rtl/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// width of the integer datapath and of every operand and result
`define XLEN 32

// the restoring divider retires one quotient bit per iteration,
// so it needs as many iterations as there are data bits
`define DIV_CYCLES `XLEN

// width of a register address
`define REG_AW 5

`endif

//--- rtl/exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

  typedef logic [`REG_AW-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLL = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SLT = 4'd7
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_BEQ = 4'd0,
    BR_BNE = 4'd1,
    BR_BLT = 4'd2,
    BR_BGE = 4'd3
  } branch_op_e;

  // read as branch_op when the branch flag is set, otherwise as alu_op
  // a division reads alu_op: ALU_ADD gives the quotient, anything else the remainder
  typedef union packed {
    alu_op_e    alu_op;
    branch_op_e branch_op;
  } func_u;

  typedef enum logic [3:0] {
    EXC_NONE       = 4'd0,
    EXC_ILLEGAL    = 4'd2,
    EXC_BREAKPOINT = 4'd3,
    EXC_ECALL      = 4'd11
  } ecause_e;

  typedef struct packed {
    logic valid;
    logic wren;
    logic rden1;
    logic rden2;
    logic use_imm;
    logic branch;
    logic jal;
    logic jalr;
    logic division;
    logic illegal;
    logic ebreak;
    logic ecall;
  } op_flags_t;

  typedef struct packed {
    op_flags_t        op;
    func_u            func;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] npc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] instr;
    reg_addr_t        raddr1;
    reg_addr_t        raddr2;
    reg_addr_t        waddr;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
  } lane_in_t;

  typedef struct packed {
    logic             valid;
    logic             wren;
    reg_addr_t        waddr;
    logic [`XLEN-1:0] wdata;
    logic             exception;
    ecause_e          ecause;
    logic [`XLEN-1:0] etval;
    logic             jump;
    logic [`XLEN-1:0] target;
  } lane_out_t;

  typedef struct packed {
    lane_in_t lane0;
    lane_in_t lane1;
  } pair_in_t;

  typedef struct packed {
    lane_out_t lane0;
    lane_out_t lane1;
  } pair_out_t;

  typedef struct packed {
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] imm;
    logic             use_imm;
    alu_op_e          alu_op;
  } alu_in_t;

  localparam lane_out_t init_lane_out = '{
    valid: 1'b0,
    wren: 1'b0,
    waddr: '0,
    wdata: '0,
    exception: 1'b0,
    ecause: EXC_NONE,
    etval: '0,
    jump: 1'b0,
    target: '0
  };

endpackage

//--- rtl/operand_forward.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module operand_forward
  import exec_pkg::*;
(
  input  pair_in_t  pair_in,
  input  pair_out_t result,
  output pair_in_t  pair_fwd
);

  function automatic logic [`XLEN-1:0] forward(
    input logic             rden,
    input reg_addr_t        raddr,
    input logic [`XLEN-1:0] rdata,
    input pair_out_t        res
  );
    logic [`XLEN-1:0] data;
    data = rdata;
    // x0 always reads as the register file gives it
    if (rden && raddr != '0) begin
      if (res.lane0.wren && res.lane0.waddr == raddr) begin
        data = res.lane0.wdata;
      end
      // lane 1 is later in program order and overrides lane 0
      if (res.lane1.wren && res.lane1.waddr == raddr) begin
        data = res.lane1.wdata;
      end
    end
    return data;
  endfunction

  always_comb begin
    pair_fwd = pair_in;
    pair_fwd.lane0.rdata1 = forward(pair_in.lane0.op.rden1, pair_in.lane0.raddr1,
                                    pair_in.lane0.rdata1, result);
    pair_fwd.lane0.rdata2 = forward(pair_in.lane0.op.rden2, pair_in.lane0.raddr2,
                                    pair_in.lane0.rdata2, result);
    pair_fwd.lane1.rdata1 = forward(pair_in.lane1.op.rden1, pair_in.lane1.raddr1,
                                    pair_in.lane1.rdata1, result);
    pair_fwd.lane1.rdata2 = forward(pair_in.lane1.op.rden2, pair_in.lane1.raddr2,
                                    pair_in.lane1.rdata2, result);
  end

endmodule

//--- rtl/int_alu.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module int_alu
  import exec_pkg::*;
(
  input  logic [`XLEN-1:0] rdata1,
  input  logic [`XLEN-1:0] rdata2,
  input  logic [`XLEN-1:0] imm,
  input  logic             use_imm,
  input  alu_op_e          alu_op,
  output logic [`XLEN-1:0] result
);

  logic [`XLEN-1:0] operand2;
  logic [4:0]       shamt;
  logic             less;

  assign operand2 = use_imm ? imm : rdata2;
  assign shamt = operand2[4:0];
  assign less = $signed(rdata1) < $signed(operand2);

  always_comb begin
    case (alu_op)
      ALU_ADD: result = rdata1 + operand2;
      ALU_SUB: result = rdata1 - operand2;
      ALU_AND: result = rdata1 & operand2;
      ALU_OR:  result = rdata1 | operand2;
      ALU_XOR: result = rdata1 ^ operand2;
      ALU_SLL: result = rdata1 << shamt;
      ALU_SRL: result = rdata1 >> shamt;
      ALU_SLT: result = {{(`XLEN-1){1'b0}}, less};
      default: result = '0;
    endcase
  end

endmodule

//--- rtl/serial_divider.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module serial_divider (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  logic             abort,
  input  logic             rem_sel,
  input  logic [`XLEN-1:0] dividend,
  input  logic [`XLEN-1:0] divisor,
  output logic [`XLEN-1:0] quotient_or_rem,
  output logic             done
);

  logic                            busy;
  logic [$clog2(`DIV_CYCLES)-1:0] count;
  logic [`XLEN-1:0]                quotient;
  logic [`XLEN-1:0]                remainder;
  logic [`XLEN-1:0]                divisor_q;
  logic                            rem_sel_q;
  logic [`XLEN:0]                  shifted;
  logic [`XLEN:0]                  diff;

  // the dividend shifts out of the quotient register MSB first
  // while the new quotient bits shift in at the bottom
  assign shifted = {remainder, quotient[`XLEN-1]};
  assign diff = shifted - {1'b0, divisor_q};

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      count <= '0;
    end else if (abort) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        if (count == `DIV_CYCLES - 1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // with a zero divisor no subtraction ever borrows, which yields all ones
  // and leaves the dividend as the remainder
  always_ff @(posedge clock) begin
    if (start && !busy) begin
      quotient <= dividend;
      remainder <= '0;
      divisor_q <= divisor;
      rem_sel_q <= rem_sel;
    end else if (busy) begin
      if (!diff[`XLEN]) begin
        remainder <= diff[`XLEN-1:0];
        quotient <= {quotient[`XLEN-2:0], 1'b1};
      end else begin
        remainder <= shifted[`XLEN-1:0];
        quotient <= {quotient[`XLEN-2:0], 1'b0};
      end
    end
  end

  assign quotient_or_rem = rem_sel_q ? remainder : quotient;

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module execute_stage
  import exec_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  pair_in_t         pair_fwd,
  input  logic             hold,
  input  logic             clear,
  input  logic [`XLEN-1:0] alu0_result,
  input  logic [`XLEN-1:0] alu1_result,
  input  logic [`XLEN-1:0] div_result,
  input  logic             div_done,
  output alu_in_t          alu0_operands,
  output alu_in_t          alu1_operands,
  output logic             div_start,
  output logic             div_abort,
  output logic             div_rem_sel,
  output logic [`XLEN-1:0] div_dividend,
  output logic [`XLEN-1:0] div_divisor,
  output pair_out_t        result,
  output logic             stall
);

  logic             cmp_sel0;
  logic             cmp_taken;
  logic [`XLEN-1:0] cmp_a;
  logic [`XLEN-1:0] cmp_b;
  branch_op_e       cmp_op;
  lane_out_t        out0;
  lane_out_t        out1;
  logic             squash1;
  logic             div_req0;
  logic             div_req1;
  logic             div_active;
  logic             div_finished;
  pair_out_t        result_next;

  function automatic lane_out_t build_lane(
    input lane_in_t         l,
    input logic [`XLEN-1:0] alu_data,
    input logic             taken,
    input logic [`XLEN-1:0] div_data
  );
    lane_out_t o;
    o = init_lane_out;
    if (l.op.valid) begin
      o.valid = 1'b1;
      o.wren = l.op.wren;
      o.waddr = l.waddr;
      o.jump = l.op.jal | l.op.jalr | (l.op.branch & taken);
      o.target = l.pc + l.imm;
      if (l.op.jalr) begin
        o.target = l.rdata1 + l.imm;
        o.target[0] = 1'b0;
      end
      if (l.op.division) begin
        o.wdata = div_data;
      end else if (o.jump) begin
        o.wdata = l.npc;
      end else begin
        o.wdata = alu_data;
      end
      if (l.op.illegal) begin
        o.ecause = EXC_ILLEGAL;
      end else if (l.op.ebreak) begin
        o.ecause = EXC_BREAKPOINT;
      end else if (l.op.ecall) begin
        o.ecause = EXC_ECALL;
      end
      if (l.op.illegal | l.op.ebreak | l.op.ecall) begin
        o.exception = 1'b1;
        o.etval = l.instr;
        o.wren = 1'b0;
        o.jump = 1'b0;
      end
    end
    return o;
  endfunction

  assign alu0_operands = '{rdata1: pair_fwd.lane0.rdata1, rdata2: pair_fwd.lane0.rdata2,
                           imm: pair_fwd.lane0.imm, use_imm: pair_fwd.lane0.op.use_imm,
                           alu_op: pair_fwd.lane0.func.alu_op};
  assign alu1_operands = '{rdata1: pair_fwd.lane1.rdata1, rdata2: pair_fwd.lane1.rdata2,
                           imm: pair_fwd.lane1.imm, use_imm: pair_fwd.lane1.op.use_imm,
                           alu_op: pair_fwd.lane1.func.alu_op};

  // one comparator for the pair, lane 0 has first claim on it
  assign cmp_sel0 = pair_fwd.lane0.op.valid & pair_fwd.lane0.op.branch;
  assign cmp_a = cmp_sel0 ? pair_fwd.lane0.rdata1 : pair_fwd.lane1.rdata1;
  assign cmp_b = cmp_sel0 ? pair_fwd.lane0.rdata2 : pair_fwd.lane1.rdata2;
  assign cmp_op = cmp_sel0 ? pair_fwd.lane0.func.branch_op : pair_fwd.lane1.func.branch_op;

  always_comb begin
    case (cmp_op)
      BR_BEQ:  cmp_taken = cmp_a == cmp_b;
      BR_BNE:  cmp_taken = cmp_a != cmp_b;
      BR_BLT:  cmp_taken = $signed(cmp_a) < $signed(cmp_b);
      BR_BGE:  cmp_taken = $signed(cmp_a) >= $signed(cmp_b);
      default: cmp_taken = 1'b0;
    endcase
  end

  assign out0 = build_lane(pair_fwd.lane0, alu0_result, cmp_taken, div_result);
  assign out1 = build_lane(pair_fwd.lane1, alu1_result, cmp_taken & ~cmp_sel0, div_result);
  assign squash1 = out0.jump | out0.exception;

  assign div_req0 = pair_fwd.lane0.op.valid & pair_fwd.lane0.op.division & ~out0.exception;
  assign div_req1 = pair_fwd.lane1.op.valid & pair_fwd.lane1.op.division & ~out1.exception
                    & ~squash1;
  assign div_dividend = div_req0 ? pair_fwd.lane0.rdata1 : pair_fwd.lane1.rdata1;
  assign div_divisor = div_req0 ? pair_fwd.lane0.rdata2 : pair_fwd.lane1.rdata2;
  assign div_rem_sel = div_req0 ? (pair_fwd.lane0.func.alu_op != ALU_ADD)
                                : (pair_fwd.lane1.func.alu_op != ALU_ADD);

  // a result that finishes under hold waits in the divider until hold drops
  assign div_start = (div_req0 | div_req1) & ~div_active & ~div_finished & ~hold & ~clear;
  assign div_abort = clear;
  assign stall = ~clear & (div_active ? ~div_done : div_start);

  always_comb begin
    result_next.lane0 = out0;
    result_next.lane1 = squash1 ? init_lane_out : out1;
    if (stall) begin
      result_next.lane0 = init_lane_out;
      result_next.lane1 = init_lane_out;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      div_active <= 1'b0;
      div_finished <= 1'b0;
    end else begin
      if (div_start) begin
        div_active <= 1'b1;
      end else if (div_done) begin
        div_active <= 1'b0;
      end
      if (div_done && hold) begin
        div_finished <= 1'b1;
      end else if (!hold) begin
        div_finished <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      result <= '{lane0: init_lane_out, lane1: init_lane_out};
    end else if (!hold) begin
      result <= result_next;
    end
  end

endmodule

//--- rtl/exec_top.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_top
  import exec_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  pair_in_t  pair_in,
  input  logic      hold,
  input  logic      clear,
  output pair_out_t result,
  output logic      stall
);

  pair_in_t         pair_fwd;
  alu_in_t          alu0_operands;
  alu_in_t          alu1_operands;
  logic [`XLEN-1:0] alu0_result;
  logic [`XLEN-1:0] alu1_result;
  logic             div_start;
  logic             div_abort;
  logic             div_rem_sel;
  logic [`XLEN-1:0] div_dividend;
  logic [`XLEN-1:0] div_divisor;
  logic [`XLEN-1:0] div_result;
  logic             div_done;

  operand_forward operand_forward_i (
    .pair_in  (pair_in),
    .result   (result),
    .pair_fwd (pair_fwd)
  );

  int_alu int_alu0_i (
    .rdata1  (alu0_operands.rdata1),
    .rdata2  (alu0_operands.rdata2),
    .imm     (alu0_operands.imm),
    .use_imm (alu0_operands.use_imm),
    .alu_op  (alu0_operands.alu_op),
    .result  (alu0_result)
  );

  int_alu int_alu1_i (
    .rdata1  (alu1_operands.rdata1),
    .rdata2  (alu1_operands.rdata2),
    .imm     (alu1_operands.imm),
    .use_imm (alu1_operands.use_imm),
    .alu_op  (alu1_operands.alu_op),
    .result  (alu1_result)
  );

  serial_divider serial_divider_i (
    .clock           (clock),
    .reset           (reset),
    .start           (div_start),
    .abort           (div_abort),
    .rem_sel         (div_rem_sel),
    .dividend        (div_dividend),
    .divisor         (div_divisor),
    .quotient_or_rem (div_result),
    .done            (div_done)
  );

  execute_stage execute_stage_i (
    .clock         (clock),
    .reset         (reset),
    .pair_fwd      (pair_fwd),
    .hold          (hold),
    .clear         (clear),
    .alu0_result   (alu0_result),
    .alu1_result   (alu1_result),
    .div_result    (div_result),
    .div_done      (div_done),
    .alu0_operands (alu0_operands),
    .alu1_operands (alu1_operands),
    .div_start     (div_start),
    .div_abort     (div_abort),
    .div_rem_sel   (div_rem_sel),
    .div_dividend  (div_dividend),
    .div_divisor   (div_divisor),
    .result        (result),
    .stall         (stall)
  );

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // reset is released just after the fourth rising edge
  initial begin
    reset = 1'b0;
    repeat (4) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

//--- testbench/exec_props.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_props
  import exec_pkg::*;
(
  input logic      clock,
  input logic      reset,
  input logic      hold,
  input logic      clear,
  input logic      stall,
  input pair_out_t result
);

  reset_gives_bubbles: assert property (
    @(posedge clock) !reset |=> !result.lane0.valid && !result.lane1.valid
  ) else $error("result lane valid after a reset cycle");

  hold_keeps_result: assert property (
    @(posedge clock) reset && hold && !clear |=> $stable(result)
  ) else $error("result changed while hold was high");

  no_stall_after_clear: assert property (
    @(posedge clock) disable iff (!reset) clear |=> !stall
  ) else $error("stall rose in the cycle after clear");

  // a division keeps the stage stalled for the divider's iterations plus the start cycle
  stall_span: assert property (
    @(posedge clock) disable iff (!reset) $rose(stall) |-> ##[1:`DIV_CYCLES+1] !stall
  ) else $error("stall stayed high too long");

endmodule

bind exec_top exec_props exec_props_i (
  .clock  (clock),
  .reset  (reset),
  .hold   (hold),
  .clear  (clear),
  .stall  (stall),
  .result (result)
);

//--- testbench/exec_tb.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_tb
  import exec_pkg::*;
();

  logic             clock;
  logic             reset;
  pair_in_t         pair_in;
  logic             hold;
  logic             clear;
  pair_out_t        result;
  logic             stall;
  integer           seed;
  int               errors;
  int               checks;
  int               tests_run;
  int               tests_failed;
  int               errors_before;
  int               wait_cycles;
  pair_in_t         p;
  pair_out_t        last_exp;
  logic [`XLEN-1:0] arch [32];
  logic [`XLEN-1:0] rf [32];

  clock_gen clock_gen_i (
    .clock (clock),
    .reset (reset)
  );

  exec_top exec_top_i (
    .clock   (clock),
    .reset   (reset),
    .pair_in (pair_in),
    .hold    (hold),
    .clear   (clear),
    .result  (result),
    .stall   (stall)
  );

  // the register file writes back whatever leaves the result register
  always @(posedge clock) begin
    if (reset && !hold) begin
      if (result.lane0.wren && result.lane0.waddr != '0) begin
        rf[result.lane0.waddr] <= result.lane0.wdata;
      end
      if (result.lane1.wren && result.lane1.waddr != '0) begin
        rf[result.lane1.waddr] <= result.lane1.wdata;
      end
    end
  end

  task automatic check_value(input string name, input logic [`XLEN-1:0] exp,
                             input logic [`XLEN-1:0] act);
    checks++;
    assert (act === exp) else begin
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_lane(input string tag, input lane_out_t exp, input lane_out_t act);
    check_value({tag, ".valid"}, exp.valid, act.valid);
    check_value({tag, ".wren"}, exp.wren, act.wren);
    check_value({tag, ".exception"}, exp.exception, act.exception);
    check_value({tag, ".jump"}, exp.jump, act.jump);
    if (exp.wren) begin
      check_value({tag, ".waddr"}, exp.waddr, act.waddr);
      check_value({tag, ".wdata"}, exp.wdata, act.wdata);
    end
    if (exp.exception) begin
      check_value({tag, ".ecause"}, exp.ecause, act.ecause);
      check_value({tag, ".etval"}, exp.etval, act.etval);
    end
    if (exp.jump) begin
      check_value({tag, ".target"}, exp.target, act.target);
    end
  endtask

  function automatic lane_in_t alu_lane(input alu_op_e op, input reg_addr_t rd,
                                        input reg_addr_t rs1, input reg_addr_t rs2,
                                        input logic use_imm, input logic [`XLEN-1:0] imm);
    lane_in_t l;
    l = '0;
    l.op.valid = 1'b1;
    l.op.wren = 1'b1;
    l.op.rden1 = 1'b1;
    l.op.rden2 = 1'b1;
    l.op.use_imm = use_imm;
    l.func.alu_op = op;
    l.waddr = rd;
    l.raddr1 = rs1;
    l.raddr2 = rs2;
    l.imm = imm;
    l.pc = {$random(seed)} & 32'h0000_fffc;
    l.npc = l.pc + 4;
    l.instr = $random(seed);
    return l;
  endfunction

  function automatic lane_in_t random_lane();
    logic [`XLEN-1:0] r;
    r = $random(seed);
    return alu_lane(alu_op_e'({1'b0, r[2:0]}), r[5:3], r[8:6], r[11:9], r[12],
                    $random(seed));
  endfunction

  function automatic lane_out_t expect_lane(input lane_in_t l, input logic may_take);
    lane_out_t o;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] op2;
    logic cond;
    o = init_lane_out;
    if (!l.op.valid) begin
      return o;
    end
    a = arch[l.raddr1];
    b = arch[l.raddr2];
    op2 = l.op.use_imm ? l.imm : b;
    o.valid = 1'b1;
    o.wren = l.op.wren;
    o.waddr = l.waddr;
    case (l.func.alu_op)
      ALU_ADD: o.wdata = a + op2;
      ALU_SUB: o.wdata = a - op2;
      ALU_AND: o.wdata = a & op2;
      ALU_OR:  o.wdata = a | op2;
      ALU_XOR: o.wdata = a ^ op2;
      ALU_SLL: o.wdata = a << op2[4:0];
      ALU_SRL: o.wdata = a >> op2[4:0];
      default: o.wdata = ($signed(a) < $signed(op2)) ? 1 : 0;
    endcase
    if (l.op.division) begin
      if (l.func.alu_op == ALU_ADD) begin
        o.wdata = (b == 0) ? '1 : a / b;
      end else begin
        o.wdata = (b == 0) ? a : a % b;
      end
    end
    case (l.func.branch_op)
      BR_BEQ:  cond = a == b;
      BR_BNE:  cond = a != b;
      BR_BLT:  cond = $signed(a) < $signed(b);
      default: cond = $signed(a) >= $signed(b);
    endcase
    o.jump = l.op.jal | l.op.jalr | (l.op.branch & may_take & cond);
    if (o.jump) begin
      o.wdata = l.npc;
      o.target = l.op.jalr ? ((a + l.imm) & ~32'd1) : l.pc + l.imm;
    end
    if (l.op.illegal | l.op.ebreak | l.op.ecall) begin
      o.exception = 1'b1;
      o.ecause = l.op.illegal ? EXC_ILLEGAL : (l.op.ebreak ? EXC_BREAKPOINT : EXC_ECALL);
      o.etval = l.instr;
      o.wren = 1'b0;
      o.jump = 1'b0;
    end
    return o;
  endfunction

  function automatic pair_in_t fill_rdata(input pair_in_t q);
    q.lane0.rdata1 = rf[q.lane0.raddr1];
    q.lane0.rdata2 = rf[q.lane0.raddr2];
    q.lane1.rdata1 = rf[q.lane1.raddr1];
    q.lane1.rdata2 = rf[q.lane1.raddr2];
    return q;
  endfunction

  // drives one pair, waits out any division stall, then checks the result
  task automatic issue_pair(input pair_in_t q, input int hold_cycles);
    pair_out_t exp;
    int stall_cycles;
    int div_expected;
    q = fill_rdata(q);
    exp.lane0 = expect_lane(q.lane0, 1'b1);
    exp.lane1 = expect_lane(q.lane1, !(q.lane0.op.valid && q.lane0.op.branch));
    if (exp.lane0.jump || exp.lane0.exception) begin
      exp.lane1 = init_lane_out;
    end
    div_expected = ((q.lane0.op.division && exp.lane0.valid && !exp.lane0.exception) ||
                    (q.lane1.op.division && exp.lane1.valid && !exp.lane1.exception))
                   ? `DIV_CYCLES + 1 : 0;
    if (exp.lane0.wren && exp.lane0.waddr != '0) arch[exp.lane0.waddr] = exp.lane0.wdata;
    if (exp.lane1.wren && exp.lane1.waddr != '0) arch[exp.lane1.waddr] = exp.lane1.wdata;
    pair_in = q;
    if (hold_cycles > 0) begin
      hold = 1'b1;
      repeat (hold_cycles) begin
        @(negedge clock);
        check_value("stall", 0, stall);
        check_lane("held.lane0", last_exp.lane0, result.lane0);
        check_lane("held.lane1", last_exp.lane1, result.lane1);
        @(posedge clock);
        #1;
      end
      hold = 1'b0;
    end
    stall_cycles = 0;
    while (1) begin
      @(negedge clock);
      if (!stall) break;
      stall_cycles++;
      if (stall_cycles > `DIV_CYCLES + 10) begin
        $display("timeout: stall did not fall within %0d cycles", `DIV_CYCLES + 10);
        $display("TB FAILED");
        $finish;
      end
    end
    check_value("stall cycles", div_expected, stall_cycles);
    @(posedge clock);
    #1;
    check_lane("result.lane0", exp.lane0, result.lane0);
    check_lane("result.lane1", exp.lane1, result.lane1);
    last_exp = exp;
  endtask

  task automatic idle();
    pair_in = '0;
    @(posedge clock);
    #1;
    last_exp = '{lane0: init_lane_out, lane1: init_lane_out};
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: passed", name);
    end
    errors_before = errors;
  endtask

  initial begin
    seed = 59399;
    pair_in = '0;
    hold = 1'b0;
    clear = 1'b0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    errors_before = 0;
    last_exp = '{lane0: init_lane_out, lane1: init_lane_out};
    for (int i = 0; i < 32; i++) begin
      arch[i] = '0;
      rf[i] = '0;
    end
    wait_cycles = 0;
    while (!reset) begin
      @(posedge clock);
      wait_cycles++;
      if (wait_cycles > 20) begin
        $display("timeout: reset was never released");
        $display("TB FAILED");
        $finish;
      end
    end
    @(posedge clock);
    #1;

    repeat (40) begin
      p.lane0 = random_lane();
      p.lane1 = random_lane();
      issue_pair(p, 0);
    end
    finish_test("alu");

    // both lanes write r5, then lane 1 writes x0
    p.lane0 = alu_lane(ALU_ADD, 5, 0, 0, 1'b1, 32'h11);
    p.lane1 = alu_lane(ALU_ADD, 5, 0, 0, 1'b1, 32'h22);
    issue_pair(p, 0);
    p.lane0 = alu_lane(ALU_ADD, 6, 5, 5, 1'b0, 0);
    p.lane1 = alu_lane(ALU_ADD, 0, 0, 0, 1'b1, 32'h55);
    issue_pair(p, 0);
    p.lane0 = alu_lane(ALU_OR, 7, 0, 6, 1'b0, 0);
    p.lane1 = alu_lane(ALU_SUB, 4, 6, 0, 1'b0, 0);
    issue_pair(p, 0);
    finish_test("forwarding");

    p.lane0 = alu_lane(ALU_ADD, 1, 0, 0, 1'b1, -5);
    p.lane1 = alu_lane(ALU_ADD, 2, 0, 0, 1'b1, 7);
    issue_pair(p, 0);
    p.lane0 = alu_lane(ALU_ADD, 0, 1, 1, 1'b0, 32'h40);
    p.lane0.op.branch = 1'b1;
    p.lane0.op.wren = 1'b0;
    p.lane0.func.branch_op = BR_BEQ;
    p.lane1 = random_lane();
    issue_pair(p, 0);
    p.lane0.raddr2 = 2;
    p.lane0.func.branch_op = BR_BLT;
    issue_pair(p, 0);
    p.lane0.func.branch_op = BR_BEQ;
    issue_pair(p, 0);
    p.lane0 = alu_lane(ALU_ADD, 3, 0, 0, 1'b0, 32'h100);
    p.lane0.op.jal = 1'b1;
    issue_pair(p, 0);
    // r3 holds the even return address of the jal, so the odd offset sets bit 0
    p.lane0 = alu_lane(ALU_ADD, 3, 3, 0, 1'b0, 32'h31);
    p.lane0.op.jalr = 1'b1;
    issue_pair(p, 0);
    finish_test("branch");

    p.lane0 = random_lane();
    p.lane0.op.illegal = 1'b1;
    p.lane0.op.ecall = 1'b1;
    p.lane1 = random_lane();
    issue_pair(p, 0);
    p.lane0 = random_lane();
    p.lane1.op.ebreak = 1'b1;
    p.lane1.op.ecall = 1'b1;
    issue_pair(p, 0);
    p.lane0.op.ecall = 1'b1;
    p.lane1 = random_lane();
    issue_pair(p, 0);
    finish_test("exception");

    idle();
    p.lane0 = alu_lane(ALU_SUB, 3, 4, 2, 1'b0, 0);
    p.lane0.op.division = 1'b1;
    p.lane1 = random_lane();
    issue_pair(p, 0);
    idle();
    p.lane0 = random_lane();
    p.lane1 = alu_lane(ALU_ADD, 5, 6, 1, 1'b0, 0);
    p.lane1.op.division = 1'b1;
    issue_pair(p, 0);
    idle();
    p.lane0 = alu_lane(ALU_ADD, 6, 7, 0, 1'b0, 0);
    p.lane0.op.division = 1'b1;
    p.lane1 = alu_lane(ALU_ADD, 1, 0, 0, 1'b1, 9);
    issue_pair(p, 0);
    idle();
    p.lane0 = alu_lane(ALU_SUB, 4, 7, 0, 1'b0, 0);
    p.lane0.op.division = 1'b1;
    issue_pair(p, 0);
    finish_test("division");

    idle();
    p.lane0 = alu_lane(ALU_ADD, 2, 3, 4, 1'b0, 0);
    p.lane0.op.division = 1'b1;
    p.lane1 = random_lane();
    issue_pair(p, 3);
    idle();
    pair_in = fill_rdata(p);
    repeat (5) begin
      @(negedge clock);
      check_value("stall", 1, stall);
      @(posedge clock);
      #1;
    end
    // the division pair stays on the inputs while clear is high
    clear = 1'b1;
    @(negedge clock);
    check_value("stall", 0, stall);
    @(posedge clock);
    #1;
    clear = 1'b0;
    pair_in = '0;
    check_value("result.lane0.valid", 0, result.lane0.valid);
    check_value("result.lane1.valid", 0, result.lane1.valid);
    idle();
    finish_test("hold and clear");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/operand_forward.sv
rtl/int_alu.sv
rtl/serial_divider.sv
rtl/execute_stage.sv
rtl/exec_top.sv
testbench/clock_gen.sv
testbench/exec_props.sv
testbench/exec_tb.sv
